//--- hdl/mpc_cfg_pkg.sv
`default_nettype none

package mpc_cfg_pkg;

    // crossbar dimensions
    localparam int NUM_CHANNELS = 3;
    localparam int NUM_BANKS    = 4;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // the bank select sits right above the byte offset within a line
    localparam int LINE_OFFSET_W = 4;
    localparam int BANK_SEL_W    = 2;

    // the write-buffer depth must equal 2**WBUF_ID_W so the free list pointers wrap cleanly
    localparam int WBUF_DEPTH = 4;
    localparam int WBUF_ID_W  = 2;

    typedef logic [$clog2(NUM_CHANNELS)-1:0] chan_id_t;
    typedef logic [BANK_SEL_W-1:0]           bank_id_t;
    typedef logic [WBUF_ID_W-1:0]            wbuf_id_t;

    typedef logic [NUM_CHANNELS-1:0] chan_vec_t;
    typedef logic [NUM_BANKS-1:0]    bank_vec_t;

endpackage

`default_nettype wire

//--- hdl/mpc_msg_pkg.sv
`default_nettype none

package mpc_msg_pkg;

    import mpc_cfg_pkg::*;

    typedef enum logic {
        MPC_OP_READ  = 1'b0,
        MPC_OP_WRITE = 1'b1
    } mpc_op_e;

    // request as issued by a channel
    typedef struct packed {
        mpc_op_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
    } chan_req_t;

    // request as seen by a bank, tagged with its source channel
    // wbuf_id is only meaningful for writes and reads carry zero
    typedef struct packed {
        mpc_op_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
        chan_id_t            chan_id;
        wbuf_id_t            wbuf_id;
    } bank_req_t;

    // response from a bank, routed back by chan_id
    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        chan_id_t            chan_id;
    } bank_rsp_t;

endpackage

`default_nettype wire

//--- hdl/xbar_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module xbar_arbiter (
    input  logic                    clk,
    input  logic                    arst_n,
    input  mpc_cfg_pkg::chan_vec_t  chan_req_valid,
    input  mpc_msg_pkg::chan_req_t  chan_req [mpc_cfg_pkg::NUM_CHANNELS],
    input  mpc_cfg_pkg::bank_vec_t  req_lane_ready,
    input  mpc_cfg_pkg::bank_vec_t  wbuf_avail,
    output mpc_cfg_pkg::chan_vec_t  req_grant [mpc_cfg_pkg::NUM_BANKS],
    output mpc_cfg_pkg::chan_vec_t  chan_req_ready,
    output mpc_cfg_pkg::bank_vec_t  wbuf_alloc,
    input  mpc_cfg_pkg::bank_vec_t  bank_rsp_valid,
    input  mpc_msg_pkg::bank_rsp_t  bank_rsp [mpc_cfg_pkg::NUM_BANKS],
    input  mpc_cfg_pkg::chan_vec_t  rsp_lane_ready,
    output mpc_cfg_pkg::bank_vec_t  rsp_grant [mpc_cfg_pkg::NUM_CHANNELS],
    output mpc_cfg_pkg::bank_vec_t  bank_rsp_ready
);
    import mpc_cfg_pkg::*;
    import mpc_msg_pkg::*;

    chan_vec_t is_write;
    bank_id_t  req_bank [NUM_CHANNELS];
    chan_vec_t req_elig [NUM_BANKS];
    chan_id_t  req_ptr  [NUM_BANKS];
    chan_id_t  req_win  [NUM_BANKS];
    bank_vec_t rsp_elig [NUM_CHANNELS];
    bank_id_t  rsp_ptr  [NUM_CHANNELS];
    bank_id_t  rsp_win  [NUM_CHANNELS];

    // a write only competes while its bank still has a free write-buffer id
    always_comb begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            req_bank[c] = chan_req[c].addr[LINE_OFFSET_W +: BANK_SEL_W];
            is_write[c] = chan_req[c].op == MPC_OP_WRITE;
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                req_elig[b][c] = chan_req_valid[c] && req_bank[c] == bank_id_t'(b) &&
                                 req_lane_ready[b] && (!is_write[c] || wbuf_avail[b]);
            end
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                rsp_elig[c][b] = bank_rsp_valid[b] && bank_rsp[b].chan_id == chan_id_t'(c) &&
                                 rsp_lane_ready[c];
            end
        end
    end

    // rotating priority per bank, search starts at the pointer
    always_comb begin
        int   idx;
        logic found;
        for (int b = 0; b < NUM_BANKS; b++) begin
            req_grant[b] = '0;
            req_win[b]   = '0;
            found        = 1'b0;
            for (int k = 0; k < NUM_CHANNELS; k++) begin
                idx = (int'(req_ptr[b]) + k) % NUM_CHANNELS;
                if (!found && req_elig[b][idx]) begin
                    found             = 1'b1;
                    req_grant[b][idx] = 1'b1;
                    req_win[b]        = chan_id_t'(idx);
                end
            end
        end
    end

    // same scheme per channel over the banks
    always_comb begin
        int   idx;
        logic found;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            rsp_grant[c] = '0;
            rsp_win[c]   = '0;
            found        = 1'b0;
            for (int k = 0; k < NUM_BANKS; k++) begin
                idx = (int'(rsp_ptr[c]) + k) % NUM_BANKS;
                if (!found && rsp_elig[c][idx]) begin
                    found             = 1'b1;
                    rsp_grant[c][idx] = 1'b1;
                    rsp_win[c]        = bank_id_t'(idx);
                end
            end
        end
    end

    always_comb begin
        chan_req_ready = '0;
        bank_rsp_ready = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            chan_req_ready = chan_req_ready | req_grant[b];
            wbuf_alloc[b]  = |(req_grant[b] & is_write);
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            bank_rsp_ready = bank_rsp_ready | rsp_grant[c];
        end
    end

    // pointers advance past the winner, only when something was granted
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                req_ptr[b] <= '0;
            end
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                rsp_ptr[c] <= '0;
            end
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (|req_grant[b]) begin
                    req_ptr[b] <= (req_win[b] == chan_id_t'(NUM_CHANNELS - 1)) ?
                                  '0 : req_win[b] + 1'b1;
                end
            end
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (|rsp_grant[c]) begin
                    rsp_ptr[c] <= (rsp_win[c] == bank_id_t'(NUM_BANKS - 1)) ?
                                  '0 : rsp_win[c] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/xbar_lane.sv
`default_nettype none
`timescale 1ns/1ns

module xbar_lane #(
    parameter type payload_t = logic,
    parameter int  N_IN      = 2
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [N_IN-1:0] in_sel,
    input  payload_t        in_data [N_IN],
    output logic            in_ready,
    output logic            out_valid,
    input  logic            out_ready,
    output payload_t        out_data
);

    logic     load;
    payload_t sel_data;
    payload_t data_q;

    // in_sel is one-hot, so at most one input matches
    always_comb begin
        load     = |in_sel;
        sel_data = in_data[0];
        for (int i = 0; i < N_IN; i++) begin
            if (in_sel[i]) begin
                sel_data = in_data[i];
            end
        end
    end

    // the slot frees up in the same cycle its item is taken downstream
    assign in_ready = !out_valid || out_ready;
    assign out_data = data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= sel_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/wbuf_id_alloc.sv
`default_nettype none
`timescale 1ns/1ns

module wbuf_id_alloc (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  alloc,
    output logic                  avail,
    output mpc_cfg_pkg::wbuf_id_t alloc_id,
    input  logic                  free_valid,
    input  mpc_cfg_pkg::wbuf_id_t free_id
);
    import mpc_cfg_pkg::*;

    wbuf_id_t           id_list [WBUF_DEPTH];
    wbuf_id_t           head;
    wbuf_id_t           tail;
    logic [WBUF_ID_W:0] count;
    logic               pop;

    // head always shows the next id to hand out
    assign avail    = count != '0;
    assign alloc_id = id_list[head];
    assign pop      = alloc && avail;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= (WBUF_ID_W + 1)'(WBUF_DEPTH);
        end else begin
            if (pop) begin
                head <= head + 1'b1;
            end
            if (free_valid) begin
                tail <= tail + 1'b1;
            end
            case ({pop, free_valid})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the list starts out holding every id in ascending order
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < WBUF_DEPTH; i++) begin
                id_list[i] <= wbuf_id_t'(i);
            end
        end else if (free_valid) begin
            id_list[tail] <= free_id;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mpc_xbar_top.sv
`default_nettype none
`timescale 1ns/1ns

module mpc_xbar_top (
    input  logic                         clk,
    input  logic                         arst_n,

    input  logic                         chan_req_valid [mpc_cfg_pkg::NUM_CHANNELS],
    output logic                         chan_req_ready [mpc_cfg_pkg::NUM_CHANNELS],
    input  mpc_msg_pkg::chan_req_t       chan_req       [mpc_cfg_pkg::NUM_CHANNELS],

    output logic                         chan_rsp_valid [mpc_cfg_pkg::NUM_CHANNELS],
    input  logic                         chan_rsp_ready [mpc_cfg_pkg::NUM_CHANNELS],
    output logic [mpc_cfg_pkg::DATA_W-1:0] chan_rsp_rdata [mpc_cfg_pkg::NUM_CHANNELS],

    output logic                         bank_req_valid [mpc_cfg_pkg::NUM_BANKS],
    input  logic                         bank_req_ready [mpc_cfg_pkg::NUM_BANKS],
    output mpc_msg_pkg::bank_req_t       bank_req       [mpc_cfg_pkg::NUM_BANKS],

    input  logic                         bank_rsp_valid [mpc_cfg_pkg::NUM_BANKS],
    output logic                         bank_rsp_ready [mpc_cfg_pkg::NUM_BANKS],
    input  mpc_msg_pkg::bank_rsp_t       bank_rsp       [mpc_cfg_pkg::NUM_BANKS],

    input  logic                         wbuf_free_valid [mpc_cfg_pkg::NUM_BANKS],
    input  mpc_cfg_pkg::wbuf_id_t        wbuf_free_id    [mpc_cfg_pkg::NUM_BANKS]
);
    import mpc_cfg_pkg::*;
    import mpc_msg_pkg::*;

    chan_vec_t         chan_req_valid_vec;
    chan_vec_t         chan_req_ready_vec;
    chan_vec_t         rsp_lane_ready;
    bank_vec_t         bank_rsp_valid_vec;
    bank_vec_t         bank_rsp_ready_vec;
    bank_vec_t         req_lane_ready;
    bank_vec_t         wbuf_avail;
    bank_vec_t         wbuf_alloc;
    chan_vec_t         req_grant [NUM_BANKS];
    bank_vec_t         rsp_grant [NUM_CHANNELS];
    wbuf_id_t          alloc_id  [NUM_BANKS];
    bank_req_t         req_lane_in [NUM_BANKS][NUM_CHANNELS];
    logic [DATA_W-1:0] rsp_lane_in [NUM_BANKS];

    xbar_arbiter i_xbar_arbiter (
        .clk            (clk               ),
        .arst_n         (arst_n            ),
        .chan_req_valid (chan_req_valid_vec),
        .chan_req       (chan_req          ),
        .req_lane_ready (req_lane_ready    ),
        .wbuf_avail     (wbuf_avail        ),
        .req_grant      (req_grant         ),
        .chan_req_ready (chan_req_ready_vec),
        .wbuf_alloc     (wbuf_alloc        ),
        .bank_rsp_valid (bank_rsp_valid_vec),
        .bank_rsp       (bank_rsp          ),
        .rsp_lane_ready (rsp_lane_ready    ),
        .rsp_grant      (rsp_grant         ),
        .bank_rsp_ready (bank_rsp_ready_vec)
    );

    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
        assign chan_req_valid_vec[c] = chan_req_valid[c];
        assign chan_req_ready[c]     = chan_req_ready_vec[c];

        // every bank's rdata is offered, the grant picks one
        xbar_lane #(
            .payload_t (logic [DATA_W-1:0]),
            .N_IN      (NUM_BANKS         )
        ) i_rsp_lane (
            .clk       (clk              ),
            .arst_n    (arst_n           ),
            .in_sel    (rsp_grant[c]     ),
            .in_data   (rsp_lane_in      ),
            .in_ready  (rsp_lane_ready[c]),
            .out_valid (chan_rsp_valid[c]),
            .out_ready (chan_rsp_ready[c]),
            .out_data  (chan_rsp_rdata[c])
        );
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign bank_rsp_valid_vec[b] = bank_rsp_valid[b];
        assign bank_rsp_ready[b]     = bank_rsp_ready_vec[b];
        assign rsp_lane_in[b]        = bank_rsp[b].rdata;

        // each channel's candidate for this bank, already tagged
        for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_in
            assign req_lane_in[b][c] = '{
                op:      chan_req[c].op,
                addr:    chan_req[c].addr,
                wdata:   chan_req[c].wdata,
                chan_id: chan_id_t'(c),
                wbuf_id: (chan_req[c].op == MPC_OP_WRITE) ? alloc_id[b] : wbuf_id_t'(0)
            };
        end

        wbuf_id_alloc i_wbuf_id_alloc (
            .clk        (clk               ),
            .arst_n     (arst_n            ),
            .alloc      (wbuf_alloc[b]     ),
            .avail      (wbuf_avail[b]     ),
            .alloc_id   (alloc_id[b]       ),
            .free_valid (wbuf_free_valid[b]),
            .free_id    (wbuf_free_id[b]   )
        );

        xbar_lane #(
            .payload_t (bank_req_t  ),
            .N_IN      (NUM_CHANNELS)
        ) i_req_lane (
            .clk       (clk              ),
            .arst_n    (arst_n           ),
            .in_sel    (req_grant[b]     ),
            .in_data   (req_lane_in[b]   ),
            .in_ready  (req_lane_ready[b]),
            .out_valid (bank_req_valid[b]),
            .out_ready (bank_req_ready[b]),
            .out_data  (bank_req[b]      )
        );
    end

endmodule

`default_nettype wire

//--- include/tb_mpc_xbar_vectors.svh
// columns: group, channel, op, address, wdata, expected bank, expected wbuf id
// group 0 is lone reads, group 1 is all channels on bank 2, group 2 is writes to bank 3
`ifndef TB_MPC_XBAR_VECTORS_SVH
`define TB_MPC_XBAR_VECTORS_SVH

typedef struct packed {
    logic [1:0]        grp;
    chan_id_t          chan;
    mpc_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    bank_id_t          exp_bank;
    wbuf_id_t          exp_wbuf;
} vec_row_t;

localparam int N_VEC = 18;

localparam vec_row_t VECTORS [N_VEC] = '{
    '{2'd0, 2'd0, MPC_OP_READ,  16'h0010, 32'h0000_1111, 2'd1, 2'd0},
    '{2'd0, 2'd1, MPC_OP_READ,  16'h0120, 32'h0000_2222, 2'd2, 2'd0},
    '{2'd0, 2'd2, MPC_OP_READ,  16'h0030, 32'h0000_3333, 2'd3, 2'd0},
    '{2'd0, 2'd0, MPC_OP_READ,  16'h0200, 32'h0000_4444, 2'd0, 2'd0},
    '{2'd1, 2'd0, MPC_OP_READ,  16'h0020, 32'hA000_0001, 2'd2, 2'd0},
    '{2'd1, 2'd1, MPC_OP_READ,  16'h10A0, 32'hB000_0001, 2'd2, 2'd0},
    '{2'd1, 2'd2, MPC_OP_READ,  16'h2020, 32'hC000_0001, 2'd2, 2'd0},
    '{2'd1, 2'd0, MPC_OP_READ,  16'h0420, 32'hA000_0002, 2'd2, 2'd0},
    '{2'd1, 2'd1, MPC_OP_READ,  16'h14E0, 32'hB000_0002, 2'd2, 2'd0},
    '{2'd1, 2'd2, MPC_OP_READ,  16'h2460, 32'hC000_0002, 2'd2, 2'd0},
    '{2'd1, 2'd0, MPC_OP_READ,  16'h0860, 32'hA000_0003, 2'd2, 2'd0},
    '{2'd1, 2'd1, MPC_OP_READ,  16'h1820, 32'hB000_0003, 2'd2, 2'd0},
    '{2'd1, 2'd2, MPC_OP_READ,  16'h28A0, 32'hC000_0003, 2'd2, 2'd0},
    '{2'd2, 2'd1, MPC_OP_WRITE, 16'h0030, 32'hD00D_0000, 2'd3, 2'd0},
    '{2'd2, 2'd1, MPC_OP_WRITE, 16'h0130, 32'hD00D_0001, 2'd3, 2'd1},
    '{2'd2, 2'd1, MPC_OP_WRITE, 16'h0270, 32'hD00D_0002, 2'd3, 2'd2},
    '{2'd2, 2'd1, MPC_OP_WRITE, 16'h03B0, 32'hD00D_0003, 2'd3, 2'd3},
    '{2'd2, 2'd1, MPC_OP_WRITE, 16'h04F0, 32'hD00D_0004, 2'd3, 2'd2}
};

`endif

//--- test/tb_mpc_xbar.sv
`default_nettype none
`timescale 1ns/1ns

module tb_mpc_xbar;
    import mpc_cfg_pkg::*;
    import mpc_msg_pkg::*;

    `include "tb_mpc_xbar_vectors.svh"

    localparam int SEED           = 32'h2f16;
    localparam int RSP_PER_BANK   = 3;
    localparam int TIMEOUT_CYCLES = 20 * N_VEC + 200;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              chan_req_valid  [NUM_CHANNELS];
    logic              chan_req_ready  [NUM_CHANNELS];
    chan_req_t         chan_req        [NUM_CHANNELS];
    logic              chan_rsp_valid  [NUM_CHANNELS];
    logic              chan_rsp_ready  [NUM_CHANNELS];
    logic [DATA_W-1:0] chan_rsp_rdata  [NUM_CHANNELS];
    logic              bank_req_valid  [NUM_BANKS];
    logic              bank_req_ready  [NUM_BANKS];
    bank_req_t         bank_req        [NUM_BANKS];
    logic              bank_rsp_valid  [NUM_BANKS];
    logic              bank_rsp_ready  [NUM_BANKS];
    bank_rsp_t         bank_rsp        [NUM_BANKS];
    logic              wbuf_free_valid [NUM_BANKS];
    wbuf_id_t          wbuf_free_id    [NUM_BANKS];

    // expected traffic is only touched at the falling edge
    bank_req_t         req_exp_q    [NUM_BANKS][$];
    logic              req_pend     [NUM_BANKS];
    bank_req_t         req_pend_val [NUM_BANKS];
    logic              req_held_v   [NUM_BANKS];
    bank_req_t         req_held     [NUM_BANKS];
    logic [DATA_W-1:0] rsp_exp_q    [NUM_CHANNELS][$];
    logic              rsp_pend     [NUM_CHANNELS];
    logic [DATA_W-1:0] rsp_pend_val [NUM_CHANNELS];
    logic              rsp_held_v   [NUM_CHANNELS];
    logic [DATA_W-1:0] rsp_held     [NUM_CHANNELS];

    int                cur_row [NUM_CHANNELS];
    int                cyc;
    logic              rand_bank_ready;
    logic              rand_rsp_ready;
    logic [DATA_W-1:0] rsp_data [NUM_BANKS][RSP_PER_BANK];
    chan_id_t          rsp_chan [NUM_BANKS][RSP_PER_BANK];

    mpc_xbar_top i_mpc_xbar_top (
        .clk             (clk            ),
        .arst_n          (arst_n         ),
        .chan_req_valid  (chan_req_valid ),
        .chan_req_ready  (chan_req_ready ),
        .chan_req        (chan_req       ),
        .chan_rsp_valid  (chan_rsp_valid ),
        .chan_rsp_ready  (chan_rsp_ready ),
        .chan_rsp_rdata  (chan_rsp_rdata ),
        .bank_req_valid  (bank_req_valid ),
        .bank_req_ready  (bank_req_ready ),
        .bank_req        (bank_req       ),
        .bank_rsp_valid  (bank_rsp_valid ),
        .bank_rsp_ready  (bank_rsp_ready ),
        .bank_rsp        (bank_rsp       ),
        .wbuf_free_valid (wbuf_free_valid),
        .wbuf_free_id    (wbuf_free_id   )
    );

    initial begin
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic fail_run(input string msg);
        $display("Something failed");
        $display("%s", msg);
        $fatal(1);
    endtask

    task automatic check_idle();
        for (int b = 0; b < NUM_BANKS; b++) begin
            assert (!bank_req_valid[b]) else fail_run($sformatf(
                "mismatch at %0t: bank_req_valid[%0d] = 1, expected 0", $time, b));
            assert (!bank_rsp_ready[b]) else fail_run($sformatf(
                "mismatch at %0t: bank_rsp_ready[%0d] = 1, expected 0", $time, b));
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            assert (!chan_rsp_valid[c]) else fail_run($sformatf(
                "mismatch at %0t: chan_rsp_valid[%0d] = 1, expected 0", $time, c));
            assert (!chan_req_ready[c]) else fail_run($sformatf(
                "mismatch at %0t: chan_req_ready[%0d] = 1, expected 0", $time, c));
        end
    endtask

    // on the bank side this checks arrival timing, the hold under back-pressure and order
    task automatic check_req_side();
        bank_req_t expd;
        vec_row_t  row;
        int        b;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (req_pend[i]) begin
                assert (bank_req_valid[i]) else fail_run($sformatf(
                    "mismatch at %0t: bank_req_valid[%0d] = 0, expected 1", $time, i));
                assert (bank_req[i] == req_pend_val[i]) else fail_run($sformatf(
                    "mismatch at %0t: bank_req[%0d] = %h, expected %h",
                    $time, i, bank_req[i], req_pend_val[i]));
            end
            if (req_held_v[i]) begin
                assert (bank_req_valid[i]) else fail_run($sformatf(
                    "mismatch at %0t: bank_req_valid[%0d] = 0, expected held 1", $time, i));
                assert (bank_req[i] == req_held[i]) else fail_run($sformatf(
                    "mismatch at %0t: bank_req[%0d] = %h, expected held %h",
                    $time, i, bank_req[i], req_held[i]));
            end
            if (bank_req_valid[i] && bank_req_ready[i]) begin
                assert (req_exp_q[i].size() > 0) else fail_run($sformatf(
                    "bank %0d delivered a request that no channel had sent", i));
                expd = req_exp_q[i].pop_front();
                assert (bank_req[i] == expd) else fail_run($sformatf(
                    "mismatch at %0t: bank_req[%0d] = %h, expected %h",
                    $time, i, bank_req[i], expd));
            end
            req_held_v[i] = bank_req_valid[i] && !bank_req_ready[i];
            req_held[i]   = bank_req[i];
            req_pend[i]   = 1'b0;
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (chan_req_valid[c] && chan_req_ready[c]) begin
                row  = VECTORS[cur_row[c]];
                b    = int'(row.exp_bank);
                expd = '{op: row.op, addr: row.addr, wdata: row.wdata,
                         chan_id: row.chan, wbuf_id: row.exp_wbuf};
                assert (!req_pend[b]) else fail_run($sformatf(
                    "bank %0d took two requests in one cycle", b));
                req_exp_q[b].push_back(expd);
                req_pend[b]     = 1'b1;
                req_pend_val[b] = expd;
            end
        end
    endtask

    task automatic check_rsp_side();
        logic [DATA_W-1:0] expd;
        int                c;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (rsp_pend[i]) begin
                assert (chan_rsp_valid[i]) else fail_run($sformatf(
                    "mismatch at %0t: chan_rsp_valid[%0d] = 0, expected 1", $time, i));
                assert (chan_rsp_rdata[i] == rsp_pend_val[i]) else fail_run($sformatf(
                    "mismatch at %0t: chan_rsp_rdata[%0d] = %h, expected %h",
                    $time, i, chan_rsp_rdata[i], rsp_pend_val[i]));
            end
            if (rsp_held_v[i]) begin
                assert (chan_rsp_valid[i]) else fail_run($sformatf(
                    "mismatch at %0t: chan_rsp_valid[%0d] = 0, expected held 1", $time, i));
                assert (chan_rsp_rdata[i] == rsp_held[i]) else fail_run($sformatf(
                    "mismatch at %0t: chan_rsp_rdata[%0d] = %h, expected held %h",
                    $time, i, chan_rsp_rdata[i], rsp_held[i]));
            end
            if (chan_rsp_valid[i] && chan_rsp_ready[i]) begin
                assert (rsp_exp_q[i].size() > 0) else fail_run($sformatf(
                    "channel %0d received a response that no bank had sent", i));
                expd = rsp_exp_q[i].pop_front();
                assert (chan_rsp_rdata[i] == expd) else fail_run($sformatf(
                    "mismatch at %0t: chan_rsp_rdata[%0d] = %h, expected %h",
                    $time, i, chan_rsp_rdata[i], expd));
            end
            rsp_held_v[i] = chan_rsp_valid[i] && !chan_rsp_ready[i];
            rsp_held[i]   = chan_rsp_rdata[i];
            rsp_pend[i]   = 1'b0;
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_rsp_valid[b] && bank_rsp_ready[b]) begin
                c = int'(bank_rsp[b].chan_id);
                assert (!rsp_pend[c]) else fail_run($sformatf(
                    "channel %0d took two responses in one cycle", c));
                rsp_exp_q[c].push_back(bank_rsp[b].rdata);
                rsp_pend[c]     = 1'b1;
                rsp_pend_val[c] = bank_rsp[b].rdata;
            end
        end
    endtask

    always @(negedge clk) begin
        cyc++;
        assert (cyc <= TIMEOUT_CYCLES) else fail_run($sformatf(
            "timeout after %0d cycles, the tests did not finish", cyc));
        if (arst_n) begin
            check_req_side();
            check_rsp_side();
        end
    end

    // downstream ready goes random only while a test asks for it
    initial begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_req_ready[b] = 1'b1;
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            chan_rsp_ready[c] = 1'b1;
        end
        forever begin
            @(posedge clk);
            #10;
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_req_ready[b] = rand_bank_ready ? ($urandom % 2 == 1) : 1'b1;
            end
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                chan_rsp_ready[c] = rand_rsp_ready ? ($urandom % 2 == 1) : 1'b1;
            end
        end
    end

    task automatic present_req(input int i);
        int c;
        c                 = int'(VECTORS[i].chan);
        cur_row[c]        = i;
        chan_req[c]       = '{op: VECTORS[i].op, addr: VECTORS[i].addr, wdata: VECTORS[i].wdata};
        chan_req_valid[c] = 1'b1;
    endtask

    task automatic await_req_accept(input int c);
        @(negedge clk);
        while (!chan_req_ready[c]) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        chan_req_valid[c] = 1'b0;
    endtask

    task automatic send_req(input int i);
        present_req(i);
        await_req_accept(int'(VECTORS[i].chan));
    endtask

    task automatic issue_group(input int c, input logic [1:0] grp);
        for (int i = 0; i < N_VEC; i++) begin
            if (VECTORS[i].grp == grp && int'(VECTORS[i].chan) == c) begin
                send_req(i);
            end
        end
    endtask

    task automatic send_rsps(input int b);
        for (int k = 0; k < RSP_PER_BANK; k++) begin
            bank_rsp[b]       = '{rdata: rsp_data[b][k], chan_id: rsp_chan[b][k]};
            bank_rsp_valid[b] = 1'b1;
            @(negedge clk);
            while (!bank_rsp_ready[b]) begin
                @(negedge clk);
            end
            @(posedge clk);
            #10;
            bank_rsp_valid[b] = 1'b0;
        end
    endtask

    function automatic int outstanding();
        int n;
        n = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            n += req_exp_q[b].size() + int'(bank_req_valid[b]);
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            n += rsp_exp_q[c].size() + int'(chan_rsp_valid[c]);
        end
        return n;
    endfunction

    task automatic wait_drained();
        do begin
            @(posedge clk);
            #10;
        end while (outstanding() != 0);
    endtask

    initial begin
        int wr_rows [$];
        int wr_chan;
        int wr_bank;
        void'($urandom(SEED));
        arst_n          = 1'b0;
        cyc             = 0;
        rand_bank_ready = 1'b0;
        rand_rsp_ready  = 1'b0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            chan_req_valid[c] = 1'b0;
            chan_req[c]       = '0;
            cur_row[c]        = 0;
            rsp_pend[c]       = 1'b0;
            rsp_held_v[c]     = 1'b0;
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_rsp_valid[b]  = 1'b0;
            bank_rsp[b]        = '0;
            wbuf_free_valid[b] = 1'b0;
            wbuf_free_id[b]    = '0;
            req_pend[b]        = 1'b0;
            req_held_v[b]      = 1'b0;
        end
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #10;
        arst_n = 1'b1;
        @(negedge clk);
        check_idle();
        @(posedge clk);
        #10;

        for (int i = 0; i < N_VEC; i++) begin
            if (VECTORS[i].grp == 2'd0) begin
                send_req(i);
                wait_drained();
            end
        end

        // all channels compete for bank 2 while it stalls at random
        rand_bank_ready = 1'b1;
        fork
            issue_group(0, 2'd1);
            issue_group(1, 2'd1);
            issue_group(2, 2'd1);
        join
        rand_bank_ready = 1'b0;
        wait_drained();

        for (int i = 0; i < N_VEC; i++) begin
            if (VECTORS[i].grp == 2'd2) begin
                wr_rows.push_back(i);
            end
        end
        wr_chan = int'(VECTORS[wr_rows[4]].chan);
        wr_bank = int'(VECTORS[wr_rows[4]].exp_bank);
        for (int k = 0; k < 4; k++) begin
            send_req(wr_rows[k]);
        end
        // the free list is empty now, so the fifth write has to wait
        present_req(wr_rows[4]);
        repeat (6) begin
            @(negedge clk);
            assert (!chan_req_ready[wr_chan]) else fail_run(
                "the fifth write was accepted while no write-buffer id was free");
        end
        @(posedge clk);
        #10;
        wbuf_free_valid[wr_bank] = 1'b1;
        wbuf_free_id[wr_bank]    = wbuf_id_t'(2);
        @(posedge clk);
        #10;
        wbuf_free_valid[wr_bank] = 1'b0;
        await_req_accept(wr_chan);
        wait_drained();

        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int k = 0; k < RSP_PER_BANK; k++) begin
                rsp_data[b][k] = $urandom;
                rsp_chan[b][k] = chan_id_t'($urandom % NUM_CHANNELS);
            end
        end
        rand_rsp_ready = 1'b1;
        fork
            send_rsps(0);
            send_rsps(1);
            send_rsps(2);
            send_rsps(3);
        join
        rand_rsp_ready = 1'b0;
        wait_drained();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
hdl/mpc_cfg_pkg.sv
hdl/mpc_msg_pkg.sv
hdl/xbar_arbiter.sv
hdl/xbar_lane.sv
hdl/wbuf_id_alloc.sv
hdl/mpc_xbar_top.sv
test/tb_mpc_xbar.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_mpc_xbar
RTL_TOP    = mpc_xbar_top
FILELIST   = files.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
